//--- mean_calc.sv
`timescale 1ns/10ps
`default_nettype none

module mean_calc (
	input  logic clk,
	input  logic rst,
	input  patch_pkg::patch_sums_t sums,
	input  logic sums_valid,
	output patch_pkg::patch_means_t means,
	output logic means_valid
);

	typedef logic [patch_pkg::sum_w-1:0] sum_t;
	typedef logic [patch_pkg::pix_w-1:0] pix_t;

	// Full width quotients of each sum
	logic [patch_pkg::patch_n-1:0][patch_pkg::sum_w-1:0] row_div;
	logic [patch_pkg::patch_n-1:0][patch_pkg::sum_w-1:0] col_div;

	// Upper quotient bits all clear
	logic fits;

	// Stage 1 registers
	logic [patch_pkg::patch_n-1:0][patch_pkg::pix_w-1:0] s1_row;
	logic [patch_pkg::patch_n-1:0][patch_pkg::pix_w-1:0] s1_col;
	logic s1_valid;

	// Stage 2 operands
	sum_t row_total;
	sum_t patch_div;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 divides every sum by the side length
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		fits = 1'b1;
		for (int i = 0; i < patch_pkg::patch_n; i++) begin
			// Truncating divide
			row_div[i] = sums.row_sum[i] / sum_t'(patch_pkg::patch_n);
			col_div[i] = sums.col_sum[i] / sum_t'(patch_pkg::patch_n);
			if (row_div[i][patch_pkg::sum_w-1:patch_pkg::pix_w] != '0)
				fits = 1'b0;
			if (col_div[i][patch_pkg::sum_w-1:patch_pkg::pix_w] != '0)
				fits = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < patch_pkg::patch_n; i++) begin
			s1_row[i] <= pix_t'(row_div[i]);
			s1_col[i] <= pix_t'(col_div[i]);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2 builds the patch mean from the row means
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		row_total = '0;
		for (int i = 0; i < patch_pkg::patch_n; i++)
			row_total = row_total + sum_t'(s1_row[i]);
		// Mean of truncated row means, truncated again
		patch_div = row_total / sum_t'(patch_pkg::patch_n);
	end

	// Row and column means move along with the patch mean
	always_ff @(posedge clk) begin
		means.row_mean <= s1_row;
		means.col_mean <= s1_col;
		means.patch_mean <= pix_t'(patch_div);
	end

	// Valid bit per stage
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			means_valid <= 1'b0;
		end else begin
			s1_valid <= sums_valid;
			means_valid <= s1_valid;
		end
	end

	// Loader only ever sums five pixels per line
	a_mean_fits: assert property (
		@(posedge clk) disable iff (rst)
		sums_valid |-> fits
	);

endmodule

`default_nettype wire

//--- patch_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module patch_cfg_regs (
	input  logic clk,
	input  logic rst,
	input  logic cfg_we,
	input  logic [patch_pkg::cfg_addr_w-1:0] cfg_addr,
	input  logic [15:0] cfg_wdata,
	output logic [15:0] cfg_rdata,
	input  logic done_pulse,
	output logic [patch_pkg::pix_w-1:0] thresh,
	output patch_pkg::flag_mode_t mode
);

	// Finished output handshakes
	logic [15:0] patch_count;

	////////////////////////////////////////////////////////////////////////////
	// Register writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			thresh <= '0;
			mode <= patch_pkg::flag_off;
			patch_count <= '0;
		end else begin
			if (cfg_we && (cfg_addr == patch_pkg::addr_thresh))
				thresh <= cfg_wdata[patch_pkg::pix_w-1:0];
			if (cfg_we && (cfg_addr == patch_pkg::addr_ctrl)) begin
				// Unknown encodings fall back to off
				case (patch_pkg::flag_mode_t'(cfg_wdata[1:0]))
					patch_pkg::flag_above: mode <= patch_pkg::flag_above;
					patch_pkg::flag_below: mode <= patch_pkg::flag_below;
					default: mode <= patch_pkg::flag_off;
				endcase
			end
			// Clear beats a same-cycle increment
			if (cfg_we && (cfg_addr == patch_pkg::addr_count))
				patch_count <= '0;
			else if (done_pulse)
				patch_count <= patch_count + 1'b1;
		end
	end

	// Read mux
	always_comb begin
		cfg_rdata = '0;
		case (cfg_addr)
			patch_pkg::addr_thresh: cfg_rdata[patch_pkg::pix_w-1:0] = thresh;
			patch_pkg::addr_ctrl: cfg_rdata[1:0] = mode;
			patch_pkg::addr_count: cfg_rdata = patch_count;
			default: cfg_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- patch_loader.sv
`timescale 1ns/10ps
`default_nettype none

module patch_loader (
	input  logic clk,
	input  logic rst,
	input  logic [patch_pkg::pix_w-1:0] pix,
	input  logic pix_req,
	output logic pix_ack,
	input  logic busy,
	output patch_pkg::patch_sums_t sums,
	output logic sums_valid
);

	// Row or column position inside the patch
	typedef logic [$clog2(patch_pkg::patch_n)-1:0] idx_t;

	patch_pkg::load_state_t state;

	idx_t row;
	idx_t col;

	// Pixel zero extended to sum width
	logic [patch_pkg::sum_w-1:0] pix_ext;

	// Position flags
	logic first;
	logic last;

	// Capture strobe for the current request
	logic take;

	assign pix_ext = {{(patch_pkg::sum_w - patch_pkg::pix_w){1'b0}}, pix};

	assign first = (row == '0) && (col == '0);
	assign last = (row == idx_t'(patch_pkg::patch_n - 1)) &&
		(col == idx_t'(patch_pkg::patch_n - 1));

	// Hold off a new patch while the result stage is occupied
	// Never stall once a patch has started
	assign take = pix_req && !(first && busy) &&
		((state == patch_pkg::idle) || (state == patch_pkg::stall));

	////////////////////////////////////////////////////////////////////////////
	// Four-phase handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= patch_pkg::idle;
			pix_ack <= 1'b0;
		end else begin
			case (state)
				patch_pkg::idle, patch_pkg::stall: begin
					if (take) begin
						// Ack one cycle after capture
						state <= patch_pkg::wait_req_low;
						pix_ack <= 1'b1;
					end else if (pix_req) begin
						state <= patch_pkg::stall;
					end else begin
						state <= patch_pkg::idle;
					end
				end
				patch_pkg::wait_req_low: begin
					// Release ack once the source drops req
					if (!pix_req) begin
						state <= patch_pkg::idle;
						pix_ack <= 1'b0;
					end
				end
				default: begin
					state <= patch_pkg::idle;
					pix_ack <= 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Raster position and end of patch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			row <= '0;
			col <= '0;
			sums_valid <= 1'b0;
		end else begin
			// Pulse after the 25th capture
			sums_valid <= take && last;
			if (take) begin
				if (col == idx_t'(patch_pkg::patch_n - 1)) begin
					col <= '0;
					if (row == idx_t'(patch_pkg::patch_n - 1))
						row <= '0;
					else
						row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Row and column accumulators
	////////////////////////////////////////////////////////////////////////////

	// First pixel restarts every sum
	always_ff @(posedge clk) begin
		if (take) begin
			for (int i = 0; i < patch_pkg::patch_n; i++) begin
				sums.row_sum[i] <= (first ? '0 : sums.row_sum[i]) +
					((row == idx_t'(i)) ? pix_ext : '0);
				sums.col_sum[i] <= (first ? '0 : sums.col_sum[i]) +
					((col == idx_t'(i)) ? pix_ext : '0);
			end
		end
	end

	// Source keeps req up until it has seen ack
	a_req_held: assert property (
		@(posedge clk) disable iff (rst)
		(pix_req && !pix_ack) |=> (pix_req || pix_ack)
	);

endmodule

`default_nettype wire

//--- patch_pkg.sv
`default_nettype none

package patch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	// Pixel and accumulated sum widths
	localparam int pix_w = 12;
	localparam int sum_w = 16;

	// Patch side length
	localparam int patch_n = 5;

	// Register map
	localparam int cfg_addr_w = 2;
	localparam logic [cfg_addr_w-1:0] addr_thresh = 2'd0;
	localparam logic [cfg_addr_w-1:0] addr_ctrl = 2'd1;
	localparam logic [cfg_addr_w-1:0] addr_count = 2'd2;

	////////////////////////////////////////////////////////////////////////////
	// Enums
	////////////////////////////////////////////////////////////////////////////

	// Pixel handshake states
	typedef enum logic [1:0] {
		idle,
		wait_req_low,
		stall
	} load_state_t;

	// Threshold compare modes
	typedef enum logic [1:0] {
		flag_off,
		flag_above,
		flag_below
	} flag_mode_t;

	////////////////////////////////////////////////////////////////////////////
	// Payload structs
	////////////////////////////////////////////////////////////////////////////

	// Index 0 is the top row and the left column
	typedef struct packed {
		logic [patch_n-1:0][sum_w-1:0] row_sum;
		logic [patch_n-1:0][sum_w-1:0] col_sum;
	} patch_sums_t;

	typedef struct packed {
		logic [patch_n-1:0][pix_w-1:0] row_mean;
		logic [patch_n-1:0][pix_w-1:0] col_mean;
		logic [pix_w-1:0] patch_mean;
	} patch_means_t;

	// Means plus threshold flag in the LSB
	typedef struct packed {
		patch_means_t means;
		logic flag;
	} patch_result_t;

endpackage

`default_nettype wire

//--- patch_stats_top.sv
`timescale 1ns/10ps
`default_nettype none

module patch_stats_top (
	input  logic clk,
	input  logic rst,
	// Pixel input
	input  logic [patch_pkg::pix_w-1:0] pix,
	input  logic pix_req,
	output logic pix_ack,
	// Register port
	input  logic cfg_we,
	input  logic [patch_pkg::cfg_addr_w-1:0] cfg_addr,
	input  logic [15:0] cfg_wdata,
	output logic [15:0] cfg_rdata,
	// Result output
	output patch_pkg::patch_result_t res,
	output logic res_req,
	input  logic res_ack
);

	// Loader to mean calculator
	patch_pkg::patch_sums_t sums;
	logic sums_valid;

	// Mean calculator to result port
	patch_pkg::patch_means_t means;
	logic means_valid;

	// Result port controls
	logic [patch_pkg::pix_w-1:0] thresh;
	patch_pkg::flag_mode_t mode;
	logic busy;
	logic done_pulse;

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	patch_loader u_loader (
		.clk        (clk),
		.rst        (rst),
		.pix        (pix),
		.pix_req    (pix_req),
		.pix_ack    (pix_ack),
		.busy       (busy),
		.sums       (sums),
		.sums_valid (sums_valid)
	);

	mean_calc u_mean (
		.clk         (clk),
		.rst         (rst),
		.sums        (sums),
		.sums_valid  (sums_valid),
		.means       (means),
		.means_valid (means_valid)
	);

	// Config block steers the flag and counts finished patches
	patch_cfg_regs u_cfg (
		.clk        (clk),
		.rst        (rst),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.cfg_rdata  (cfg_rdata),
		.done_pulse (done_pulse),
		.thresh     (thresh),
		.mode       (mode)
	);

	result_port u_result (
		.clk         (clk),
		.rst         (rst),
		.means       (means),
		.means_valid (means_valid),
		.thresh      (thresh),
		.mode        (mode),
		.res         (res),
		.res_req     (res_req),
		.res_ack     (res_ack),
		.busy        (busy),
		.done_pulse  (done_pulse)
	);

endmodule

`default_nettype wire

//--- result_port.sv
`timescale 1ns/10ps
`default_nettype none

module result_port (
	input  logic clk,
	input  logic rst,
	input  patch_pkg::patch_means_t means,
	input  logic means_valid,
	input  logic [patch_pkg::pix_w-1:0] thresh,
	input  patch_pkg::flag_mode_t mode,
	output patch_pkg::patch_result_t res,
	output logic res_req,
	input  logic res_ack,
	output logic busy,
	output logic done_pulse
);

	// Holding register occupied
	logic held;

	// Flag for the incoming patch
	logic flag_next;

	// Compare against threshold
	always_comb begin
		case (mode)
			patch_pkg::flag_above: flag_next = means.patch_mean > thresh;
			patch_pkg::flag_below: flag_next = means.patch_mean < thresh;
			default: flag_next = 1'b0;
		endcase
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (means_valid) begin
			res.means <= means;
			res.flag <= flag_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Source side of the output handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
			res_req <= 1'b0;
			done_pulse <= 1'b0;
		end else begin
			done_pulse <= 1'b0;
			if (means_valid) begin
				// Raise req the cycle after the means land
				held <= 1'b1;
				res_req <= 1'b1;
			end else if (res_req && res_ack) begin
				// Sink has taken the result
				res_req <= 1'b0;
			end else if (held && !res_req && !res_ack) begin
				// Ack back low closes the transfer
				held <= 1'b0;
				done_pulse <= 1'b1;
			end
		end
	end

	// Covers the cycle of means_valid itself
	assign busy = held || means_valid;

	// Loader back-pressure keeps the holding register from being overrun
	a_no_overrun: assert property (
		@(posedge clk) disable iff (rst)
		means_valid |-> !held
	);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the patch statistics testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f src.f --top-module tb_patch_stats -o tb_patch_stats
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_patch_stats)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qxF "TEST RESULT: PASS"; then
	exit 0
fi
exit 1

//--- src.f
patch_pkg.sv
patch_loader.sv
mean_calc.sv
patch_cfg_regs.sv
result_port.sv
patch_stats_top.sv
tb_patch_stats.sv

//--- tb_patch_stats.sv
`timescale 1ns/10ps
`default_nettype none

module tb_patch_stats;

	typedef logic [patch_pkg::pix_w-1:0] pix_t;
	typedef int patch_pix_t [patch_pkg::patch_n * patch_pkg::patch_n];

	// Run length feeds the watchdog
	localparam int n_patches = 21;
	localparam int burst_n = 6;
	localparam int cycles_per_pixel = 12;
	localparam int clk_period = 100;
	localparam int timeout_ns = n_patches * 25 * cycles_per_pixel * clk_period + 50000;

	logic clk;
	logic rst;
	pix_t pix;
	logic pix_req;
	logic pix_ack;
	logic cfg_we;
	logic [patch_pkg::cfg_addr_w-1:0] cfg_addr;
	logic [15:0] cfg_wdata;
	logic [15:0] cfg_rdata;
	patch_pkg::patch_result_t res;
	logic res_req;
	logic res_ack;

	// Expected results in send order
	patch_pkg::patch_result_t exp_q [$];
	patch_pkg::patch_result_t exp_head;
	int exp_count = 0;

	int errors = 0;
	int sent = 0;
	int accepted = 0;
	int done_count = 0;
	int hold_max = 4;

	// Pixels of the patch being sent and the active config
	patch_pix_t cur_px;
	int cur_thresh;
	patch_pkg::flag_mode_t cur_mode;

	patch_stats_top dut0 (
		.clk       (clk),
		.rst       (rst),
		.pix       (pix),
		.pix_req   (pix_req),
		.pix_ack   (pix_ack),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.res       (res),
		.res_req   (res_req),
		.res_ack   (res_ack)
	);

	always #(clk_period / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Raster order, index row * 5 + col
	function automatic patch_pkg::patch_result_t expected_result(input patch_pix_t px,
		input int th, input patch_pkg::flag_mode_t md);
		patch_pkg::patch_result_t r;
		int rs;
		int cs;
		int mean_total;
		int pm;
		mean_total = 0;
		for (int i = 0; i < patch_pkg::patch_n; i++) begin
			rs = 0;
			cs = 0;
			for (int j = 0; j < patch_pkg::patch_n; j++) begin
				rs += px[i * patch_pkg::patch_n + j];
				cs += px[j * patch_pkg::patch_n + i];
			end
			// Integer divide truncates
			r.means.row_mean[i] = pix_t'(rs / patch_pkg::patch_n);
			r.means.col_mean[i] = pix_t'(cs / patch_pkg::patch_n);
			mean_total += rs / patch_pkg::patch_n;
		end
		// Mean of the truncated row means
		pm = mean_total / patch_pkg::patch_n;
		r.means.patch_mean = pix_t'(pm);
		case (md)
			patch_pkg::flag_above: r.flag = (pm > th);
			patch_pkg::flag_below: r.flag = (pm < th);
			default: r.flag = 1'b0;
		endcase
		return r;
	endfunction

	function automatic void refresh_head();
		exp_count = exp_q.size();
		if (exp_count != 0)
			exp_head = exp_q[0];
		else
			exp_head = '0;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Accepted result against queue head
	a_means_match: assert property (@(posedge clk) disable iff (rst)
		(res_req && res_ack) |-> (res.means == exp_head.means))
	else begin
		errors++;
		$display("Error at %0t ns: means differ, patch mean %0d expected %0d",
			$time, res.means.patch_mean, exp_head.means.patch_mean);
	end

	a_flag_match: assert property (@(posedge clk) disable iff (rst)
		(res_req && res_ack) |-> (res.flag == exp_head.flag))
	else begin
		errors++;
		$display("Error at %0t ns: flag %0b expected %0b", $time, res.flag, exp_head.flag);
	end

	a_not_extra: assert property (@(posedge clk) disable iff (rst)
		(res_req && res_ack) |-> (exp_count != 0))
	else begin
		errors++;
		$display("A result was accepted with no patch outstanding at %0t ns", $time);
	end

	// Pixel port phases
	a_pix_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(pix_ack) |-> $past(pix_req))
	else begin
		errors++;
		$display("pix_ack rose without a pending pix_req at %0t ns", $time);
	end

	a_pix_ack_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(pix_ack) |-> !$past(pix_req))
	else begin
		errors++;
		$display("pix_ack fell while pix_req was still high at %0t ns", $time);
	end

	// Result port phases
	a_res_req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(res_req) |-> !$past(res_ack))
	else begin
		errors++;
		$display("res_req rose while res_ack was still high at %0t ns", $time);
	end

	a_res_req_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(res_req) |-> $past(res_ack))
	else begin
		errors++;
		$display("res_req fell before res_ack was seen at %0t ns", $time);
	end

	a_res_stable: assert property (@(posedge clk) disable iff (rst)
		res_req |=> (!res_req || $stable(res)))
	else begin
		errors++;
		$display("res changed while res_req was high at %0t ns", $time);
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic fill_uniform(input int value);
		foreach (cur_px[k])
			cur_px[k] = value;
	endtask

	task automatic fill_random();
		foreach (cur_px[k])
			cur_px[k] = int'($urandom_range((1 << patch_pkg::pix_w) - 1));
	endtask

	// Called just after a rising edge
	task automatic write_reg(input logic [patch_pkg::cfg_addr_w-1:0] addr,
		input logic [15:0] data);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(posedge clk);
		#1;
		cfg_we = 1'b0;
	endtask

	task automatic set_config(input int th, input patch_pkg::flag_mode_t md);
		write_reg(patch_pkg::addr_thresh, 16'(th));
		write_reg(patch_pkg::addr_ctrl, 16'(md));
		cur_thresh = th;
		cur_mode = md;
	endtask

	// Count read sampled mid cycle
	task automatic check_count(input int expected);
		cfg_addr = patch_pkg::addr_count;
		@(negedge clk);
		a_count: assert (cfg_rdata == 16'(expected))
		else begin
			errors++;
			$display("Error at %0t ns: patch count %0d expected %0d",
				$time, cfg_rdata, expected);
		end
		@(posedge clk);
		#1;
	endtask

	// Model result queued before the pixels go out
	task automatic send_patch();
		exp_q.push_back(expected_result(cur_px, cur_thresh, cur_mode));
		refresh_head();
		sent++;
		for (int k = 0; k < patch_pkg::patch_n * patch_pkg::patch_n; k++) begin
			pix = pix_t'(cur_px[k]);
			pix_req = 1'b1;
			do begin
				@(posedge clk);
				#1;
			end while (!pix_ack);
			pix_req = 1'b0;
			do begin
				@(posedge clk);
				#1;
			end while (pix_ack);
		end
	endtask

	// Wait for every queued result plus the count update
	task automatic drain();
		while (exp_q.size() != 0 || res_req || res_ack) begin
			@(posedge clk);
			#1;
		end
		repeat (3) @(posedge clk);
		#1;
	endtask

	// Threshold one below, at and one above the patch mean
	task automatic sweep_thresholds(input patch_pkg::flag_mode_t md);
		patch_pkg::patch_result_t probe;
		int m;
		int th;
		fill_random();
		probe = expected_result(cur_px, 0, patch_pkg::flag_off);
		m = int'(probe.means.patch_mean);
		for (int d = -1; d <= 1; d++) begin
			th = m + d;
			if (th < 0)
				th = 0;
			if (th > (1 << patch_pkg::pix_w) - 1)
				th = (1 << patch_pkg::pix_w) - 1;
			set_config(th, md);
			send_patch();
			drain();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Result sink with random ack delay
	////////////////////////////////////////////////////////////////////////////

	initial begin : sink
		int hold;
		res_ack = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (res_req) begin
				hold = int'($urandom_range(hold_max));
				repeat (hold) begin
					@(posedge clk);
					#1;
				end
				res_ack = 1'b1;
				do begin
					@(posedge clk);
					#1;
				end while (res_req);
				if (exp_q.size() != 0)
					void'(exp_q.pop_front());
				refresh_head();
				accepted++;
				hold = int'($urandom_range(3));
				repeat (hold) begin
					@(posedge clk);
					#1;
				end
				res_ack = 1'b0;
				done_count++;
			end
		end
	end

	initial begin : watchdog
		#(timeout_ns);
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : main
		int count_base;
		int gap;
		clk = 1'b0;
		rst = 1'b1;
		pix = '0;
		pix_req = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		cur_thresh = 0;
		cur_mode = patch_pkg::flag_off;
		void'($urandom(32'h3d6b));
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// Extremes and random pixels, flag off
		fill_uniform((1 << patch_pkg::pix_w) - 1);
		send_patch();
		fill_uniform(0);
		send_patch();
		repeat (2) begin
			fill_random();
			send_patch();
		end
		drain();
		check_count(done_count);

		sweep_thresholds(patch_pkg::flag_off);
		sweep_thresholds(patch_pkg::flag_above);
		sweep_thresholds(patch_pkg::flag_below);

		// Long ack hold off, ack delay stays inside one patch time
		set_config(2000, patch_pkg::flag_above);
		hold_max = 30;
		for (int k = 0; k < burst_n; k++) begin
			fill_random();
			send_patch();
			// Gap of two or more cycles lands the first pixel while busy
			gap = (k % 2 == 0) ? 0 : 2 + int'($urandom_range(4));
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
		drain();
		hold_max = 4;
		check_count(done_count);

		// Counter clear then recount
		write_reg(patch_pkg::addr_count, 16'h0);
		count_base = done_count;
		check_count(0);
		repeat (2) begin
			fill_random();
			send_patch();
		end
		drain();
		check_count(done_count - count_base);

		a_all_out: assert (exp_q.size() == 0 && accepted == sent)
		else begin
			errors++;
			$display("Results lost or duplicated: %0d patches sent, %0d results accepted",
				sent, accepted);
		end

		$display("Summary: %0d errors, %0d patches sent, %0d results accepted",
			errors, sent, accepted);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
